/* flist.f */
common/gpioPkg.sv
csr/gpioCsr.sv
hdl/gpioTimeBase.sv
hdl/gpioLedDriver.sv
hdl/gpioTop.sv
dv/gpioTb.sv

/* Makefile */
# Verilator build, run and lint for the GPIO peripheral

TOP := gpioTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -o simv

run: build
	./obj_dir/simv > sim.log 2>&1; cat sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "Simulation reported errors"; exit 1; fi
	@grep -q ">>> PASS" sim.log || (echo "Simulation ended without a result"; exit 1)

lint:
	verilator --lint-only -Wall --top-module gpioTop \
		common/gpioPkg.sv csr/gpioCsr.sv hdl/gpioTimeBase.sv \
		hdl/gpioLedDriver.sv hdl/gpioTop.sv

clean:
	rm -rf obj_dir sim.log

/* dv/gpioTb.sv */
//----------------------------------------
// GPIO peripheral testbench
// Random bus traffic and pin checks against a register model
//----------------------------------------
`timescale 1ns/1ps

module gpioTb
	import gpioPkg::*;
();

	localparam int timeoutCycles = 4000;	// Tests need about 1700 cycles
	localparam logic [7:0] foreignBlock = 8'h02;	// Some other peripheral

	logic                  iSysClk;
	logic                  arstN;
	logic [busDataBit-1:0] usiWd;
	logic [busAdrsBit-1:0] usiAdrs;
	logic                  usiWCke;
	logic [busDataBit-1:0] usiRd;
	logic                  usiREd;
	logic [gpioWidth-1:0]  gpio;

	// Register model
	logic [gpioWidth-1:0]    mEn;
	logic [flashModeBit-1:0] mMode;
	logic [pwmDutyBit-1:0]   mDuty;
	logic [intervalBit-1:0]  mInterval;

	logic [31:0] lfsr;	// Random source state
	int          errCnt;
	int          checkCnt;
	int          testCnt;
	int          cycleCnt;

	gpioTop gpioTop_inst (
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.usiWd   (usiWd),
		.usiAdrs (usiAdrs),
		.usiWCke (usiWCke),
		.usiRd   (usiRd),
		.usiREd  (usiREd),
		.gpio    (gpio)
	);

	always #10 iSysClk = ~iSysClk;	// 20 ns period

	//----------------------------------------
	// Random numbers and model
	//----------------------------------------
	// Taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		lfsrNext = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	task automatic takeBits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrNext(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] regAdrs(input logic [7:0] blk, input logic [7:0] ofs);
		regAdrs = {16'h0000, blk, ofs};
	endfunction

	task automatic modelWrite(input logic [7:0] ofs, input logic [31:0] data);
		case (ofs)
			adrsGpioEn:    mEn       = data[7:0];
			adrsFlashMode: mMode     = data[3:0];
			adrsDuty:      mDuty     = data[7:0];
			adrsInterval:  mInterval = data[15:0];
			default:       ;	// Unmapped
		endcase
	endtask

	function automatic logic [31:0] modelRead(input logic [7:0] ofs);
		case (ofs)
			adrsGpioEn:    modelRead = {24'h0, mEn};
			adrsFlashMode: modelRead = {28'h0, mMode};
			adrsDuty:      modelRead = {24'h0, mDuty};
			adrsInterval:  modelRead = {16'h0, mInterval};
			default:       modelRead = '0;
		endcase
	endfunction

	//----------------------------------------
	// Checks and bus tasks
	//----------------------------------------
	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
		checkCnt++;
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
			errCnt++;
		end
	endtask

	// Strobe for one cycle, then check the read pulse of the write address
	task automatic busWrite(input logic [31:0] adrs, input logic [31:0] data);
		logic        hit;
		logic [31:0] oldVal;
		hit    = (adrs[15:8] == blockAdrsMap);
		oldVal = modelRead(adrs[7:0]);	// Read data shows the value before the write
		@(posedge iSysClk);
		usiAdrs <= adrs;
		usiWd   <= data;
		usiWCke <= 1'b1;
		@(posedge iSysClk);
		usiAdrs <= '0;	// Idle outside the block
		usiWCke <= 1'b0;
		if (hit)
			modelWrite(adrs[7:0], data);
		@(negedge iSysClk);
		checkValue({31'h0, usiREd}, {31'h0, hit}, "write valid");
		if (hit)
			checkValue(usiRd, oldVal, "write read data");
	endtask

	task automatic busRead(input logic [31:0] adrs);
		logic hit;
		hit = (adrs[15:8] == blockAdrsMap);
		@(posedge iSysClk);
		usiAdrs <= adrs;
		@(posedge iSysClk);
		usiAdrs <= '0;
		@(negedge iSysClk);	// Valid and data settled
		checkValue({31'h0, usiREd}, {31'h0, hit}, "read valid");
		if (hit)
			checkValue(usiRd, modelRead(adrs[7:0]), "read data");
	endtask

	task automatic reportTest(input string name, input int errStart);
		testCnt++;
		$display("Test %0d %-16s %s", testCnt, name, (errCnt == errStart) ? "ok" : "failed");
	endtask

	//----------------------------------------
	// Timeout
	//----------------------------------------
	initial
	begin
		cycleCnt = 0;
		while (cycleCnt < timeoutCycles)
		begin
			@(posedge iSysClk);
			cycleCnt++;
		end
		$display("Run stopped after %0d cycles without finishing the tests", cycleCnt);
		$display(">>> FAIL");
		$finish;
	end

	//----------------------------------------
	// Test sequence
	//----------------------------------------
	initial
	begin
		logic [31:0] rnd;
		logic [31:0] sel;
		logic [31:0] data;
		logic [7:0]  ofs;
		logic [7:0]  blk;
		logic [7:0]  mask;
		logic [7:0]  prevGpio;
		int          iv;
		int          run;
		int          changes;
		int          guard;
		int          onCnt;
		int          errStart;

		iSysClk = 1'b0;
		arstN   = 1'b0;
		usiWd   = '0;
		usiAdrs = '0;
		usiWCke = 1'b0;
		lfsr    = 32'hb8c;
		errCnt  = 0;
		checkCnt  = 0;
		testCnt   = 0;
		mEn       = enResetVal;
		mMode     = modeResetVal;
		mDuty     = dutyResetVal;
		mInterval = intervalResetVal;

		// Reset values
		errStart = errCnt;
		@(posedge iSysClk);
		@(negedge iSysClk);
		checkValue({24'h0, gpio}, 32'h0, "gpio in reset");
		checkValue({31'h0, usiREd}, 32'h0, "valid in reset");
		checkValue(usiRd, 32'h0, "read data in reset");
		@(posedge iSysClk);
		arstN <= 1'b1;
		repeat (2) @(posedge iSysClk);
		@(negedge iSysClk);
		checkValue({24'h0, gpio}, 32'h0000_00ff, "gpio after reset");
		busRead(regAdrs(blockAdrsMap, adrsGpioEn));
		busRead(regAdrs(blockAdrsMap, adrsFlashMode));
		busRead(regAdrs(blockAdrsMap, adrsDuty));
		busRead(regAdrs(blockAdrsMap, adrsInterval));
		reportTest("reset values", errStart);

		// Random traffic, sel 0..3 mapped, 4..6 any offset, 7 foreign block at a mapped offset
		errStart = errCnt;
		for (int n = 0; n < 40; n++)
		begin
			takeBits(1, rnd);
			takeBits(3, sel);
			takeBits(8, data);
			if (sel < 4)
				ofs = {4'h0, sel[1:0], 2'b00};
			else if (sel == 7)
				ofs = {4'h0, data[1:0], 2'b00};
			else
				ofs = data[7:0];
			blk = (sel == 7) ? foreignBlock : blockAdrsMap;
			takeBits(32, data);
			if (rnd[0])
				busWrite(regAdrs(blk, ofs), data);
			else
				busRead(regAdrs(blk, ofs));
		end
		// Read back every register after the traffic
		for (int n = 0; n < 4; n++)
			busRead(regAdrs(blockAdrsMap, 8'(n * 4)));
		reportTest("register traffic", errStart);

		// Static mode
		errStart = errCnt;
		busWrite(regAdrs(blockAdrsMap, adrsFlashMode), {28'h0, modeStatic});
		for (int n = 0; n < 5; n++)
		begin
			takeBits(8, rnd);
			busWrite(regAdrs(blockAdrsMap, adrsGpioEn), rnd);
			@(posedge iSysClk);
			@(negedge iSysClk);
			checkValue({24'h0, gpio}, {24'h0, mEn}, "static level");
		end
		reportTest("static mode", errStart);

		// Blink mode, 17 edges give 8 full periods
		errStart = errCnt;
		takeBits(4, rnd);
		iv = int'(rnd[3:0]);
		takeBits(8, rnd);
		mask = rnd[7:0] | 8'h01;	// Never all off
		busWrite(regAdrs(blockAdrsMap, adrsGpioEn), {24'h0, mask});
		busWrite(regAdrs(blockAdrsMap, adrsInterval), 32'(iv));
		busWrite(regAdrs(blockAdrsMap, adrsFlashMode), {28'h0, modeBlink});
		repeat (3) @(posedge iSysClk);	// Skip the mode switch edge
		@(negedge iSysClk);
		prevGpio = gpio;
		run      = 0;
		changes  = 0;
		guard    = 0;
		while (changes < 17 && guard < 18 * (iv + 1) + 40)
		begin
			@(negedge iSysClk);
			guard++;
			checkCnt++;
			assert ((gpio == mask) || (gpio == 8'h00))
			else
			begin
				$display("CHECK FAILED at %0t ns: blink level %h not mask %h or zero",
					$time, gpio, mask);
				errCnt++;
			end
			if (gpio != prevGpio)
			begin
				if (changes > 0)
					checkValue(run, iv + 1, "blink half period");
				run = 1;
				changes++;
			end
			else
				run++;
			prevGpio = gpio;
		end
		if (changes < 17)
		begin
			$display("Blink output stopped toggling after %0d changes", changes);
			errCnt++;
		end
		reportTest("blink mode", errStart);

		// PWM mode, any 256 cycle window holds duty high cycles
		errStart = errCnt;
		busWrite(regAdrs(blockAdrsMap, adrsFlashMode), {28'h0, modePwm});
		for (int k = 0; k < 4; k++)
		begin
			takeBits(8, rnd);
			busWrite(regAdrs(blockAdrsMap, adrsDuty), rnd);
			repeat (3) @(posedge iSysClk);	// New duty reaches the pins
			onCnt = 0;
			repeat (256)
			begin
				@(negedge iSysClk);
				if (gpio == mask)
					onCnt++;
				else
					checkValue({24'h0, gpio}, 32'h0, "pwm off level");
			end
			checkValue(onCnt, {24'h0, mDuty}, "pwm high count");
		end
		reportTest("pwm mode", errStart);

		// Undefined mode from lit pins, then back to static
		errStart = errCnt;
		busWrite(regAdrs(blockAdrsMap, adrsFlashMode), {28'h0, modeStatic});	// Pins show the mask
		busWrite(regAdrs(blockAdrsMap, adrsFlashMode), 32'd3);
		@(posedge iSysClk);
		@(negedge iSysClk);
		checkValue({24'h0, gpio}, 32'h0, "undefined mode level");
		busWrite(regAdrs(blockAdrsMap, adrsFlashMode), {28'h0, modeStatic});
		@(posedge iSysClk);
		@(negedge iSysClk);
		checkValue({24'h0, gpio}, {24'h0, mEn}, "static restored");
		reportTest("undefined mode", errStart);

		$display("Summary %0d tests, %0d checks, %0d errors", testCnt, checkCnt, errCnt);
		if (errCnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* hdl/gpioTop.sv */
//----------------------------------------
// GPIO subsystem top
// Connects CSR, time base and driver to bus and pins
//----------------------------------------
`timescale 1ns/1ps

module gpioTop
	import gpioPkg::*;
(
	// Clock and reset
	input  logic                  iSysClk,
	input  logic                  arstN,
	// Register bus
	input  logic [busDataBit-1:0] usiWd,
	input  logic [busAdrsBit-1:0] usiAdrs,
	input  logic                  usiWCke,
	output logic [busDataBit-1:0] usiRd,
	output logic                  usiREd,
	// Pins
	output logic [gpioWidth-1:0]  gpio
);

	// CSR settings
	logic [gpioWidth-1:0]    gpioEn;
	logic [flashModeBit-1:0] flashMode;
	logic [pwmDutyBit-1:0]   duty;
	logic [intervalBit-1:0]  interval;
	// Time base to driver
	logic                    intervalTick;
	logic                    pwmLevel;

	gpioCsr gpioCsr_inst (
		.iSysClk   (iSysClk),
		.arstN     (arstN),
		.usiWd     (usiWd),
		.usiAdrs   (usiAdrs),
		.usiWCke   (usiWCke),
		.usiRd     (usiRd),
		.usiREd    (usiREd),
		.gpioEn    (gpioEn),
		.flashMode (flashMode),
		.duty      (duty),
		.interval  (interval)
	);

	gpioTimeBase gpioTimeBase_inst (
		.iSysClk      (iSysClk),
		.arstN        (arstN),
		.interval     (interval),
		.duty         (duty),
		.intervalTick (intervalTick),
		.pwmLevel     (pwmLevel)
	);

	gpioLedDriver gpioLedDriver_inst (
		.iSysClk      (iSysClk),
		.arstN        (arstN),
		.gpioEn       (gpioEn),
		.flashMode    (flashMode),
		.intervalTick (intervalTick),
		.pwmLevel     (pwmLevel),
		.gpio         (gpio)
	);

endmodule

/* hdl/gpioLedDriver.sv */
//----------------------------------------
// GPIO output driver
// Blink phase and per-mode gating of the enable mask
//----------------------------------------
`timescale 1ns/1ps

module gpioLedDriver
	import gpioPkg::*;
(
	input  logic                    iSysClk,
	input  logic                    arstN,
	input  logic [gpioWidth-1:0]    gpioEn,			// Enable mask from CSR
	input  logic [flashModeBit-1:0] flashMode,		// Lighting mode from CSR
	input  logic                    intervalTick,	// Blink toggle pulse
	input  logic                    pwmLevel,		// PWM gate
	output logic [gpioWidth-1:0]    gpio
);

	//----------------------------------------
	// Blink phase
	//----------------------------------------
	logic blinkPhase;

	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
			blinkPhase <= 1'b0;
		else if (intervalTick)
			blinkPhase <= ~blinkPhase;	// Toggle each interval
	end

	//----------------------------------------
	// Mode select
	//----------------------------------------
	logic [gpioWidth-1:0] gpioNext;

	always_comb
	begin
		case (flashMode)
			modeStatic:
			begin
				gpioNext = gpioEn;	// Follow the mask
			end
			modeBlink:
			begin
				// Enabled pins lit in phase 1 only
				gpioNext = blinkPhase ? gpioEn : '0;
			end
			modePwm:
			begin
				gpioNext = pwmLevel ? gpioEn : '0;	// Gated by duty
			end
			default:
			begin
				gpioNext = '0;	// Undefined mode, all off
			end
		endcase
	end

	//----------------------------------------
	// Output register
	//----------------------------------------
	// Pins low in reset
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
			gpio <= '0;
		else
			gpio <= gpioNext;
	end

endmodule

/* hdl/gpioTimeBase.sv */
//----------------------------------------
// GPIO time base
// Blink interval prescaler and PWM duty compare
//----------------------------------------
`timescale 1ns/1ps

module gpioTimeBase
	import gpioPkg::*;
(
	input  logic                   iSysClk,
	input  logic                   arstN,
	input  logic [intervalBit-1:0] interval,	// Wrap value, tick every interval+1
	input  logic [pwmDutyBit-1:0]  duty,		// High cycles per PWM period
	output logic                   intervalTick,
	output logic                   pwmLevel
);

	//----------------------------------------
	// Interval prescaler
	//----------------------------------------
	logic [intervalBit-1:0] preCnt;
	logic                   preWrap;

	// Greater-or-equal so a lowered interval wraps at once
	assign preWrap = (preCnt >= interval);

	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			preCnt       <= '0;
			intervalTick <= 1'b0;
		end
		else
		begin
			preCnt       <= preWrap ? '0 : preCnt + 1'b1;
			intervalTick <= preWrap;	// One pulse per wrap
		end
	end

	//----------------------------------------
	// PWM counter
	//----------------------------------------
	logic [pwmDutyBit-1:0] pwmCnt;	// Free running, 256 cycle period

	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			pwmCnt   <= '0;
			pwmLevel <= 1'b0;
		end
		else
		begin
			pwmCnt   <= pwmCnt + 1'b1;
			pwmLevel <= (pwmCnt < duty);	// Exactly duty high cycles
		end
	end

endmodule

/* csr/gpioCsr.sv */
//----------------------------------------
// GPIO control and status registers
// Decodes bus writes and returns registered read data
//----------------------------------------
`timescale 1ns/1ps

module gpioCsr
	import gpioPkg::*;
(
	// Clock and reset
	input  logic                    iSysClk,
	input  logic                    arstN,
	// Bus slave
	input  logic [busDataBit-1:0]   usiWd,		// Write data
	input  logic [busAdrsBit-1:0]   usiAdrs,	// Read and write address
	input  logic                    usiWCke,	// Write strobe
	output logic [busDataBit-1:0]   usiRd,		// Read data
	output logic                    usiREd,		// Read valid pulse
	// Settings out
	output logic [gpioWidth-1:0]    gpioEn,
	output logic [flashModeBit-1:0] flashMode,
	output logic [pwmDutyBit-1:0]   duty,
	output logic [intervalBit-1:0]  interval
);

	//----------------------------------------
	// Address decode
	//----------------------------------------
	logic       blockHit;	// Address falls in this block
	logic       wrHit;		// Write to this block
	logic [7:0] regOfs;		// Register offset

	assign regOfs   = usiAdrs[7:0];
	assign blockHit = (usiAdrs[15:8] == blockAdrsMap);
	assign wrHit    = blockHit & usiWCke;

	//----------------------------------------
	// Register map
	//----------------------------------------
	logic [gpioWidth-1:0]    rGpioEn;		// Pin on/off mask
	logic [flashModeBit-1:0] rFlashMode;	// Lighting mode
	logic [pwmDutyBit-1:0]   rDuty;			// PWM high cycles per period
	logic [intervalBit-1:0]  rInterval;		// Blink prescaler wrap value

	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			rGpioEn    <= enResetVal;
			rFlashMode <= modeResetVal;
			rDuty      <= dutyResetVal;
			rInterval  <= intervalResetVal;
		end
		else if (wrHit)
		begin
			case (regOfs)
				adrsGpioEn:    rGpioEn    <= usiWd[gpioWidth-1:0];
				adrsFlashMode: rFlashMode <= usiWd[flashModeBit-1:0];
				adrsDuty:      rDuty      <= usiWd[pwmDutyBit-1:0];
				adrsInterval:  rInterval  <= usiWd[intervalBit-1:0];
				default:       ;	// Unmapped offset, write dropped
			endcase
		end
	end

	// Settings go out straight from the registers
	assign gpioEn    = rGpioEn;
	assign flashMode = rFlashMode;
	assign duty      = rDuty;
	assign interval  = rInterval;

	//----------------------------------------
	// Read path
	//----------------------------------------
	logic [busDataBit-1:0] rdMux;	// Addressed register, zero extended
	logic [busDataBit-1:0] rRd;
	logic                  rREd;

	always_comb
	begin
		case (regOfs)
			adrsGpioEn:    rdMux = {{(busDataBit-gpioWidth){1'b0}}, rGpioEn};
			adrsFlashMode: rdMux = {{(busDataBit-flashModeBit){1'b0}}, rFlashMode};
			adrsDuty:      rdMux = {{(busDataBit-pwmDutyBit){1'b0}}, rDuty};
			adrsInterval:  rdMux = {{(busDataBit-intervalBit){1'b0}}, rInterval};
			default:       rdMux = '0;	// Unmapped reads as zero
		endcase
	end

	// Capture on every hit, strobe or not
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			rRd  <= '0;
			rREd <= 1'b0;
		end
		else
		begin
			rREd <= blockHit;	// Valid one cycle after the address
			if (blockHit)
				rRd <= rdMux;	// Value before any same-cycle write
		end
	end

	assign usiRd  = rRd;
	assign usiREd = rREd;

endmodule

/* common/gpioPkg.sv */
//----------------------------------------
// GPIO peripheral shared definitions
// Bus widths, register map, mode codes and reset values
//----------------------------------------
package gpioPkg;

	//----------------------------------------
	// Register bus
	//----------------------------------------
	localparam int busAdrsBit = 32;	// Address width
	localparam int busDataBit = 32;	// Data width

	// Block select in address bits 15:8
	localparam logic [7:0] blockAdrsMap = 8'h01;

	// Register offsets in address bits 7:0
	localparam logic [7:0] adrsGpioEn    = 8'h00;	// Output enable mask
	localparam logic [7:0] adrsFlashMode = 8'h04;	// Lighting mode
	localparam logic [7:0] adrsDuty      = 8'h08;	// PWM duty
	localparam logic [7:0] adrsInterval  = 8'h0C;	// Blink interval

	//----------------------------------------
	// GPIO settings
	//----------------------------------------
	localparam int gpioWidth    = 8;	// Number of output pins
	localparam int flashModeBit = 4;
	localparam int pwmDutyBit   = 8;	// 256 cycle PWM period
	localparam int intervalBit  = 16;	// Prescaler width

	// Lighting modes, other codes force all pins low
	localparam logic [flashModeBit-1:0] modeStatic = 4'd0;
	localparam logic [flashModeBit-1:0] modeBlink  = 4'd1;
	localparam logic [flashModeBit-1:0] modePwm    = 4'd2;

	// Register reset values
	localparam logic [gpioWidth-1:0]    enResetVal       = 8'hFF;	// All pins enabled
	localparam logic [flashModeBit-1:0] modeResetVal     = 4'd0;
	localparam logic [pwmDutyBit-1:0]   dutyResetVal     = 8'd0;
	localparam logic [intervalBit-1:0]  intervalResetVal = 16'd0;

endpackage
